// File: fp_add.f
common/fp_add_pkg.sv
fp_add/fp_add_ctrl.sv
fp_add/fp_unpack_classify.sv
fp_add/fp_align_sum.sv
fp_add/fp_normalize_round.sv
fp_add/fp_add_top.sv
bench/fp_add_assertions.sv
bench/fp_add_tb.sv

// File: bench/fp_add_tb.sv
/*
 * Directed testbench for the FP adder: basic add/sub with latency,
 * rounding modes, special values, range limits and random integer sums
 */
`timescale 1ns/1ps

module fp_add_tb;
  import fp_add_pkg::*;

  localparam int          CLK_PERIOD      = 8;
  localparam int          NUM_OPS         = 37;
  localparam int          WATCHDOG_CYCLES = NUM_OPS * 12 + 40;
  localparam int          MAX_WAIT        = 20;     // Cycles to wait for done
  localparam int unsigned SEED            = 32'h8b23_d7b6;

  // Flag vector order {nv, of, uf, nx}
  localparam logic [3:0] NO_FLAGS = 4'b0000;
  localparam logic [3:0] F_NV     = 4'b1000;
  localparam logic [3:0] F_OF     = 4'b0100;
  localparam logic [3:0] F_UF     = 4'b0010;
  localparam logic [3:0] F_NX     = 4'b0001;

  logic        clk;
  logic        reset_n;
  logic        start;
  logic        is_sub;
  logic [2:0]  rounding_mode;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic        busy;
  logic        done;
  logic [31:0] result;
  logic        flag_nv;
  logic        flag_of;
  logic        flag_uf;
  logic        flag_nx;

  int check_count;
  int error_count;

  fp_add_top dut_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .is_sub        (is_sub),
    .rounding_mode (rounding_mode),
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .busy          (busy),
    .done          (done),
    .result        (result),
    .flag_nv       (flag_nv),
    .flag_of       (flag_of),
    .flag_uf       (flag_uf),
    .flag_nx       (flag_nx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ============================================================
  // Helpers
  // ============================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("MISMATCH %s: got %h, expected %h", name, got, expected);
    end
  endtask

  // Exact single-precision bits of a small integer
  function automatic logic [31:0] int_to_float(input int value);
    logic        sign;
    logic [31:0] mag;
    int          msb;
    if (value == 0) begin
      return 32'h0000_0000;
    end
    sign = (value < 0);
    mag  = sign ? -value : value;
    msb  = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) msb = i;
    end
    return {sign, 8'(127 + msb), 23'(mag << (23 - msb))};
  endfunction

  // One operation, optionally with a stray start pulse while busy
  task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
                        input logic [2:0] mode, input bit glitch,
                        output logic [31:0] res, output logic [3:0] flags,
                        output int cycles, output bit busy_ok);
    cycles  = 0;
    busy_ok = 1'b1;
    @(negedge clk);
    operand_a     = a;
    operand_b     = b;
    is_sub        = sub;
    rounding_mode = mode;
    start         = 1'b1;
    @(posedge clk);                                 // Sampling edge
    do begin
      @(negedge clk);
      cycles++;
      start = 1'b0;
      if (glitch && cycles == 1) begin
        start     = 1'b1;                           // Must be ignored
        operand_a = ~a;
        operand_b = a;
        is_sub    = ~sub;
      end
      if (!done && !busy) busy_ok = 1'b0;
    end while (!done && cycles < MAX_WAIT);
    if (!done) begin
      error_count++;
      $display("ERROR: done did not rise within %0d cycles of start", MAX_WAIT);
    end
    res   = result;
    flags = {flag_nv, flag_of, flag_uf, flag_nx};
  endtask

  task automatic check_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
                          input logic [2:0] mode, input logic [31:0] exp_res,
                          input logic [3:0] exp_flags);
    logic [31:0] res;
    logic [3:0]  flags;
    int          cycles;
    bit          busy_ok;
    run_op(a, b, sub, mode, 1'b0, res, flags, cycles, busy_ok);
    check_value("result", res, exp_res);
    check_value("flags", 32'(flags), 32'(exp_flags));
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("%-16s finished, %0d errors", name, error_count - errors_before);
  endtask

  // ============================================================
  // Tests
  // ============================================================
  task automatic test_basic();
    int          errors_before;
    logic [31:0] res;
    logic [3:0]  flags;
    int          cycles;
    bit          busy_ok;
    errors_before = error_count;
    check_value("busy", 32'(busy), 32'h0);          // State left by reset
    check_value("done", 32'(done), 32'h0);
    check_value("result", result, 32'h0);
    check_value("flags", 32'({flag_nv, flag_of, flag_uf, flag_nx}), 32'h0);
    run_op(32'h3F80_0000, 32'h4000_0000, 1'b0, RM_RNE, 1'b0, res, flags, cycles, busy_ok);
    check_value("result", res, 32'h4040_0000);
    check_value("flags", 32'(flags), 32'(NO_FLAGS));
    check_value("latency", 32'(cycles), 32'd6);
    check_value("busy", 32'(busy_ok), 32'h1);
    run_op(32'h4040_0000, 32'h3F80_0000, 1'b1, RM_RNE, 1'b0, res, flags, cycles, busy_ok);
    check_value("result", res, 32'h4000_0000);
    check_value("flags", 32'(flags), 32'(NO_FLAGS));
    check_value("latency", 32'(cycles), 32'd6);
    check_value("busy", 32'(busy_ok), 32'h1);
    report_test("basic_add_sub", errors_before);
  endtask

  // 1.0 + 2^-24 sits exactly halfway between two floats
  task automatic test_rounding();
    int errors_before;
    errors_before = error_count;
    check_op(32'h3F80_0000, 32'h3380_0000, 1'b0, RM_RNE, 32'h3F80_0000, F_NX);
    check_op(32'h3F80_0000, 32'h3380_0000, 1'b0, RM_RTZ, 32'h3F80_0000, F_NX);
    check_op(32'h3F80_0000, 32'h3380_0000, 1'b0, RM_RDN, 32'h3F80_0000, F_NX);
    check_op(32'h3F80_0000, 32'h3380_0000, 1'b0, RM_RUP, 32'h3F80_0001, F_NX);
    check_op(32'h3F80_0000, 32'h3380_0000, 1'b0, RM_RMM, 32'h3F80_0001, F_NX);
    check_op(32'hBF80_0000, 32'hB380_0000, 1'b0, RM_RDN, 32'hBF80_0001, F_NX);
    check_op(32'hBF80_0000, 32'hB380_0000, 1'b0, RM_RUP, 32'hBF80_0000, F_NX);
    report_test("rounding_modes", errors_before);
  endtask

  task automatic test_specials();
    int errors_before;
    errors_before = error_count;
    check_op(32'h7F80_0001, 32'h3F80_0000, 1'b0, RM_RNE, CANONICAL_NAN, F_NV);
    check_op(32'h7F80_0000, 32'h7F80_0000, 1'b1, RM_RNE, CANONICAL_NAN, F_NV);
    check_op(32'h7F80_0000, 32'h3F80_0000, 1'b0, RM_RNE, 32'h7F80_0000, NO_FLAGS);
    check_op(32'h0000_0000, 32'h8000_0000, 1'b0, RM_RNE, 32'h0000_0000, NO_FLAGS);
    check_op(32'h0000_0000, 32'h8000_0000, 1'b0, RM_RDN, 32'h8000_0000, NO_FLAGS);
    report_test("special_values", errors_before);
  endtask

  task automatic test_range();
    int errors_before;
    errors_before = error_count;
    check_op(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0, RM_RNE, 32'h7F80_0000, F_OF | F_NX);
    check_op(32'h0080_0001, 32'h0080_0000, 1'b1, RM_RNE, 32'h0000_0000, F_UF | F_NX);
    check_op(32'h3F80_0000, 32'h3F7F_FFFF, 1'b1, RM_RNE, 32'h3380_0000, NO_FLAGS);
    report_test("over_underflow", errors_before);
  endtask

  // Integers below 2^20 add and subtract exactly in single precision
  task automatic test_random_ints();
    int          errors_before;
    int          a_int;
    int          b_int;
    logic        sub;
    logic [31:0] res;
    logic [3:0]  flags;
    int          cycles;
    bit          busy_ok;
    errors_before = error_count;
    for (int n = 0; n < 20; n++) begin
      a_int = int'($urandom % 32'h0010_0000);
      b_int = int'($urandom % 32'h0010_0000);
      sub   = $urandom % 2;
      run_op(int_to_float(a_int), int_to_float(b_int), sub, RM_RNE, 1'b1,
             res, flags, cycles, busy_ok);
      check_value("result", res, int_to_float(sub ? a_int - b_int : a_int + b_int));
      check_value("flags", 32'(flags), 32'(NO_FLAGS));
      check_value("latency", 32'(cycles), 32'd6);
    end
    report_test("random_ints", errors_before);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    int unsigned seed_ret;
    int          total_errors;
    reset_n       = 1'b0;
    start         = 1'b0;
    is_sub        = 1'b0;
    rounding_mode = RM_RNE;
    operand_a     = '0;
    operand_b     = '0;
    check_count   = 0;
    error_count   = 0;
    seed_ret      = $urandom(SEED);
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    test_basic();
    test_rounding();
    test_specials();
    test_range();
    test_random_ints();

    repeat (2) @(negedge clk);                      // Let the last assertions settle
    total_errors = error_count + dut_i.ctrl_i.assert_i.error_count;
    $display("Summary: %0d checks, %0d check errors, %0d assertion errors",
             check_count, error_count, dut_i.ctrl_i.assert_i.error_count);
    if (total_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

// File: bench/fp_add_assertions.sv
/*
 * Sequencer protocol checks for the FP adder, bound to fp_add_ctrl.
 * Covers the done pulse width, busy/done exclusion and start-to-done latency
 */
`timescale 1ns/1ps

module fp_add_assertions (
  input logic clk,
  input logic reset_n,
  input logic start,
  input logic busy,
  input logic done
);

  int unsigned error_count = 0;                     // Read by the testbench

  logic accepted;

  // Start only counts while the sequencer sits idle
  assign accepted = start && !busy && !done;

  property done_one_cycle;
    @(posedge clk) disable iff (!reset_n) done |=> !done;
  endproperty

  property busy_done_exclusive;
    @(posedge clk) disable iff (!reset_n) !(busy && done);
  endproperty

  // Five busy cycles, then done in the sixth
  property start_to_done;
    @(posedge clk) disable iff (!reset_n) accepted |=> !done [*5] ##1 done;
  endproperty

  done_pulse_a: assert property (done_one_cycle) else begin
    error_count++;
    $error("done stayed high for more than one cycle");
  end

  busy_done_a: assert property (busy_done_exclusive) else begin
    error_count++;
    $error("busy and done high together");
  end

  latency_a: assert property (start_to_done) else begin
    error_count++;
    $error("done did not follow the accepted start after six cycles");
  end

endmodule

bind fp_add_ctrl fp_add_assertions assert_i (
  .clk     (clk),
  .reset_n (reset_n),
  .start   (start),
  .busy    (busy),
  .done    (done)
);

// File: fp_add/fp_add_top.sv
/*
 * Single-precision FP add/subtract, one operation at a time.
 * The controller steps the unpack, align/sum and normalize/round stages
 */
`timescale 1ns/1ps

module fp_add_top (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            start,
  input  logic                            is_sub,
  input  logic [2:0]                      rounding_mode,
  input  logic [fp_add_pkg::FP_WIDTH-1:0] operand_a,
  input  logic [fp_add_pkg::FP_WIDTH-1:0] operand_b,
  output logic                            busy,
  output logic                            done,
  output logic [fp_add_pkg::FP_WIDTH-1:0] result,
  output logic                            flag_nv,
  output logic                            flag_of,
  output logic                            flag_uf,
  output logic                            flag_nx
);
  import fp_add_pkg::*;

  // Stage enables
  logic unpack_en;
  logic align_en;
  logic compute_en;
  logic normalize_en;
  logic round_en;

  // Unpacked operands
  logic                 sign_a;
  logic                 sign_b;
  logic [EXP_WIDTH-1:0] exp_a;
  logic [EXP_WIDTH-1:0] exp_b;
  logic [MAN_WIDTH:0]   sig_a;
  logic [MAN_WIDTH:0]   sig_b;
  rm_t                  rm;

  // Special-case bypass
  logic                special_valid;
  logic [FP_WIDTH-1:0] special_result;
  logic                special_nv;

  // Magnitude sum
  logic [SIG_WIDTH:0]   sum_mag;
  logic                 sum_sign;
  logic [EXP_WIDTH-1:0] exp_big;

  fp_add_ctrl ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .unpack_en    (unpack_en),
    .align_en     (align_en),
    .compute_en   (compute_en),
    .normalize_en (normalize_en),
    .round_en     (round_en),
    .busy         (busy),
    .done         (done)
  );

  fp_unpack_classify unpack_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .unpack_en      (unpack_en),
    .operand_a      (operand_a),
    .operand_b      (operand_b),
    .is_sub         (is_sub),
    .rounding_mode  (rounding_mode),
    .sign_a         (sign_a),
    .sign_b         (sign_b),
    .exp_a          (exp_a),
    .exp_b          (exp_b),
    .sig_a          (sig_a),
    .sig_b          (sig_b),
    .rm             (rm),
    .special_valid  (special_valid),
    .special_result (special_result),
    .special_nv     (special_nv)
  );

  fp_align_sum align_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .align_en   (align_en),
    .compute_en (compute_en),
    .sign_a     (sign_a),
    .sign_b     (sign_b),
    .exp_a      (exp_a),
    .exp_b      (exp_b),
    .sig_a      (sig_a),
    .sig_b      (sig_b),
    .sum_mag    (sum_mag),
    .sum_sign   (sum_sign),
    .exp_big    (exp_big)
  );

  fp_normalize_round round_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .normalize_en   (normalize_en),
    .round_en       (round_en),
    .sum_mag        (sum_mag),
    .sum_sign       (sum_sign),
    .exp_big        (exp_big),
    .rm             (rm),
    .special_valid  (special_valid),
    .special_result (special_result),
    .special_nv     (special_nv),
    .result         (result),
    .flag_nv        (flag_nv),
    .flag_of        (flag_of),
    .flag_uf        (flag_uf),
    .flag_nx        (flag_nx)
  );

endmodule

// File: fp_add/fp_normalize_round.sv
/*
 * Leading-zero normalization and IEEE rounding. Handles exponent
 * overflow, flush-to-zero underflow and the special-case bypass
 */
`timescale 1ns/1ps

module fp_normalize_round (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             normalize_en,
  input  logic                             round_en,
  input  logic [fp_add_pkg::SIG_WIDTH:0]   sum_mag,
  input  logic                             sum_sign,
  input  logic [fp_add_pkg::EXP_WIDTH-1:0] exp_big,
  input  fp_add_pkg::rm_t                  rm,
  input  logic                             special_valid,
  input  logic [fp_add_pkg::FP_WIDTH-1:0]  special_result,
  input  logic                             special_nv,
  output logic [fp_add_pkg::FP_WIDTH-1:0]  result,
  output logic                             flag_nv,
  output logic                             flag_of,
  output logic                             flag_uf,
  output logic                             flag_nx
);
  import fp_add_pkg::*;

  // Position of the leading one, counted from the hidden bit
  function automatic logic [$clog2(SIG_WIDTH)-1:0] lead_zeros(
    input logic [SIG_WIDTH-1:0] value
  );
    logic [$clog2(SIG_WIDTH)-1:0] count;
    count = '0;
    for (int i = 0; i < SIG_WIDTH; i++) begin
      if (value[i]) begin
        count = ($clog2(SIG_WIDTH))'(SIG_WIDTH - 1 - i);   // Highest set bit wins
      end
    end
    return count;
  endfunction

  logic [$clog2(SIG_WIDTH)-1:0] lz;

  // Normalized value
  logic [SIG_WIDTH-1:0]         norm_sig;
  logic signed [EXP_WIDTH+1:0]  norm_exp;                 // Room for under and overflow
  logic                         norm_sign;
  logic                         norm_zero;

  // Rounding
  logic                         guard_bit;
  logic                         round_bit;
  logic                         sticky_bit;
  logic                         inexact;
  logic                         round_up;
  logic [EXP_WIDTH+MAN_WIDTH+1:0] rnd_word;
  logic signed [EXP_WIDTH+1:0]  rnd_exp;

  fp_word_u res_w;
  logic     nv_next;
  logic     of_next;
  logic     uf_next;
  logic     nx_next;

  // ============================================================
  // Normalize
  // ============================================================
  assign lz = lead_zeros(sum_mag[SIG_WIDTH-1:0]);

  always_ff @(posedge clk) begin
    if (normalize_en) begin
      if (sum_mag[SIG_WIDTH]) begin
        // Carry out, shift right and keep the dropped bit in sticky
        norm_sig <= {sum_mag[SIG_WIDTH:2], sum_mag[1] | sum_mag[0]};
        norm_exp <= {2'b00, exp_big} + 1'b1;
      end else begin
        norm_sig <= sum_mag[SIG_WIDTH-1:0] << lz;
        norm_exp <= {2'b00, exp_big} - lz;
      end
      norm_sign <= sum_sign;
      norm_zero <= (sum_mag == '0);
    end
  end

  // ============================================================
  // Round
  // ============================================================
  assign guard_bit  = norm_sig[2];
  assign round_bit  = norm_sig[1];
  assign sticky_bit = norm_sig[0];
  assign inexact    = guard_bit || round_bit || sticky_bit;

  always_comb begin
    case (rm)
      RM_RNE:  round_up = guard_bit && (round_bit || sticky_bit || norm_sig[3]);
      RM_RUP:  round_up = !norm_sign && inexact;
      RM_RDN:  round_up = norm_sign && inexact;
      RM_RMM:  round_up = guard_bit;
      default: round_up = 1'b0;                           // RTZ and unused codes
    endcase
  end

  // Increment over exponent and fraction, a fraction carry bumps the exponent
  assign rnd_word = {norm_exp, norm_sig[SIG_WIDTH-2:3]} + round_up;
  assign rnd_exp  = rnd_word[EXP_WIDTH+MAN_WIDTH+1:MAN_WIDTH];

  always_comb begin
    res_w.bits = '0;
    nv_next    = 1'b0;
    of_next    = 1'b0;
    uf_next    = 1'b0;
    nx_next    = 1'b0;
    if (special_valid) begin
      res_w.bits = special_result;
      nv_next    = special_nv;
    end else if (norm_zero) begin
      res_w.fields.sign = (rm == RM_RDN);                 // Exact cancellation
    end else if (rnd_exp >= EXP_MAX) begin
      res_w.fields.sign = norm_sign;
      res_w.fields.exp  = '1;
      of_next           = 1'b1;
      nx_next           = 1'b1;
    end else if (norm_exp < 1) begin
      res_w.fields.sign = norm_sign;                      // Flush to signed zero
      uf_next           = 1'b1;
      nx_next           = 1'b1;
    end else begin
      res_w.fields.sign = norm_sign;
      res_w.fields.exp  = rnd_word[EXP_WIDTH+MAN_WIDTH-1:MAN_WIDTH];
      res_w.fields.frac = rnd_word[MAN_WIDTH-1:0];
      nx_next           = inexact;
    end
  end

  // Held until the next operation rounds
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nv <= 1'b0;
      flag_of <= 1'b0;
      flag_uf <= 1'b0;
      flag_nx <= 1'b0;
    end else if (round_en) begin
      result  <= res_w.bits;
      flag_nv <= nv_next;
      flag_of <= of_next;
      flag_uf <= uf_next;
      flag_nx <= nx_next;
    end
  end

endmodule

// File: fp_add/fp_align_sum.sv
/*
 * Significand alignment with sticky collection, followed by the
 * magnitude add or subtract. Result sign follows the larger operand
 */
`timescale 1ns/1ps

module fp_align_sum (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             align_en,
  input  logic                             compute_en,
  input  logic                             sign_a,
  input  logic                             sign_b,
  input  logic [fp_add_pkg::EXP_WIDTH-1:0] exp_a,
  input  logic [fp_add_pkg::EXP_WIDTH-1:0] exp_b,
  input  logic [fp_add_pkg::MAN_WIDTH:0]   sig_a,
  input  logic [fp_add_pkg::MAN_WIDTH:0]   sig_b,
  output logic [fp_add_pkg::SIG_WIDTH:0]   sum_mag,
  output logic                             sum_sign,
  output logic [fp_add_pkg::EXP_WIDTH-1:0] exp_big
);
  import fp_add_pkg::*;

  logic                 a_big;
  logic [EXP_WIDTH-1:0] exp_diff;
  logic [SIG_WIDTH-1:0] small_ext;
  logic [SIG_WIDTH-1:0] small_shift;
  logic [SIG_WIDTH-1:0] lost_mask;
  logic                 sticky;

  // Aligned operands
  logic [SIG_WIDTH-1:0] big_al;
  logic [SIG_WIDTH-1:0] small_al;
  logic                 big_sign;
  logic                 eff_sub;

  // ============================================================
  // Align
  // ============================================================
  // Full magnitude compare, so the subtract never goes negative
  assign a_big     = {exp_a, sig_a} >= {exp_b, sig_b};
  assign exp_diff  = a_big ? (exp_a - exp_b) : (exp_b - exp_a);
  assign small_ext = {(a_big ? sig_b : sig_a), 3'b000};

  // Beyond SIG_WIDTH the mask covers every bit and only sticky is left
  assign small_shift = small_ext >> exp_diff;
  assign lost_mask   = ~({SIG_WIDTH{1'b1}} << exp_diff);
  assign sticky      = |(small_ext & lost_mask);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      eff_sub <= 1'b0;
    end else if (align_en) begin
      eff_sub <= sign_a ^ sign_b;
    end
  end

  always_ff @(posedge clk) begin
    if (align_en) begin
      big_al   <= {(a_big ? sig_a : sig_b), 3'b000};
      small_al <= {small_shift[SIG_WIDTH-1:1], small_shift[0] | sticky};
      big_sign <= a_big ? sign_a : sign_b;
      exp_big  <= a_big ? exp_a : exp_b;
    end
  end

  // ============================================================
  // Compute
  // ============================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sum_sign <= 1'b0;
    end else if (compute_en) begin
      sum_sign <= big_sign;
    end
  end

  always_ff @(posedge clk) begin
    if (compute_en) begin
      if (eff_sub) begin
        sum_mag <= {1'b0, big_al} - {1'b0, small_al};
      end else begin
        sum_mag <= {1'b0, big_al} + {1'b0, small_al};  // MSB catches the carry
      end
    end
  end

endmodule

// File: fp_add/fp_unpack_classify.sv
/*
 * Operand capture and classification. Flushes subnormals to zero and
 * forms the NaN, infinity and zero results that bypass the datapath
 */
`timescale 1ns/1ps

module fp_unpack_classify (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             unpack_en,
  input  logic [fp_add_pkg::FP_WIDTH-1:0]  operand_a,
  input  logic [fp_add_pkg::FP_WIDTH-1:0]  operand_b,
  input  logic                             is_sub,
  input  logic [2:0]                       rounding_mode,
  output logic                             sign_a,
  output logic                             sign_b,
  output logic [fp_add_pkg::EXP_WIDTH-1:0] exp_a,
  output logic [fp_add_pkg::EXP_WIDTH-1:0] exp_b,
  output logic [fp_add_pkg::MAN_WIDTH:0]   sig_a,
  output logic [fp_add_pkg::MAN_WIDTH:0]   sig_b,
  output fp_add_pkg::rm_t                  rm,
  output logic                             special_valid,
  output logic [fp_add_pkg::FP_WIDTH-1:0]  special_result,
  output logic                             special_nv
);
  import fp_add_pkg::*;

  fp_word_u word_a;
  fp_word_u word_b;

  // Operand classes
  logic nan_a;
  logic nan_b;
  logic inf_a;
  logic inf_b;
  logic zero_a;
  logic zero_b;
  logic zero_sign;

  assign word_a.bits = operand_a;
  assign word_b.bits = operand_b;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      nan_a  <= 1'b0;
      nan_b  <= 1'b0;
      inf_a  <= 1'b0;
      inf_b  <= 1'b0;
      zero_a <= 1'b0;
      zero_b <= 1'b0;
      rm     <= RM_RNE;
    end else if (unpack_en) begin
      nan_a  <= (word_a.fields.exp == '1) && (word_a.fields.frac != '0);
      nan_b  <= (word_b.fields.exp == '1) && (word_b.fields.frac != '0);
      inf_a  <= (word_a.fields.exp == '1) && (word_a.fields.frac == '0);
      inf_b  <= (word_b.fields.exp == '1) && (word_b.fields.frac == '0);
      zero_a <= (word_a.fields.exp == '0);          // Subnormals count as zero
      zero_b <= (word_b.fields.exp == '0);
      rm     <= rm_t'(rounding_mode);
    end
  end

  // Fields with the hidden bit made explicit
  always_ff @(posedge clk) begin
    if (unpack_en) begin
      sign_a <= word_a.fields.sign;
      sign_b <= word_b.fields.sign ^ is_sub;        // a - b becomes a + (-b)
      exp_a  <= word_a.fields.exp;
      exp_b  <= word_b.fields.exp;
      sig_a  <= (word_a.fields.exp == '0) ? '0 : {1'b1, word_a.fields.frac};
      sig_b  <= (word_b.fields.exp == '0) ? '0 : {1'b1, word_b.fields.frac};
    end
  end

  // Exact zero sum is negative only for -0 + -0, or under RDN
  assign zero_sign = (sign_a && sign_b) || ((sign_a || sign_b) && (rm == RM_RDN));

  always_comb begin
    special_valid  = 1'b1;
    special_nv     = 1'b0;
    special_result = CANONICAL_NAN;
    if (nan_a || nan_b) begin
      special_nv = 1'b1;
    end else if (inf_a && inf_b && (sign_a != sign_b)) begin
      special_nv = 1'b1;                            // inf - inf
    end else if (inf_a) begin
      special_result = {sign_a, {EXP_WIDTH{1'b1}}, {MAN_WIDTH{1'b0}}};
    end else if (inf_b) begin
      special_result = {sign_b, {EXP_WIDTH{1'b1}}, {MAN_WIDTH{1'b0}}};
    end else if (zero_a && zero_b) begin
      special_result = {zero_sign, {(FP_WIDTH-1){1'b0}}};
    end else if (zero_a) begin
      special_result = {sign_b, exp_b, sig_b[MAN_WIDTH-1:0]};
    end else if (zero_b) begin
      special_result = {sign_a, exp_a, sig_a[MAN_WIDTH-1:0]};
    end else begin
      special_valid = 1'b0;                         // Both finite and nonzero
    end
  end

endmodule

// File: fp_add/fp_add_ctrl.sv
/*
 * Stage sequencer for the FP adder. Walks one operation through
 * unpack, align, compute, normalize, round and done
 */
`timescale 1ns/1ps

module fp_add_ctrl (
  input  logic clk,
  input  logic reset_n,
  input  logic start,
  output logic unpack_en,
  output logic align_en,
  output logic compute_en,
  output logic normalize_en,
  output logic round_en,
  output logic busy,
  output logic done
);
  import fp_add_pkg::*;

  logic [2:0] state;
  logic [2:0] next_state;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // One step per clock, only IDLE waits
  always_comb begin
    case (state)
      ST_IDLE:      next_state = start ? ST_UNPACK : ST_IDLE;
      ST_UNPACK:    next_state = ST_ALIGN;
      ST_ALIGN:     next_state = ST_COMPUTE;
      ST_COMPUTE:   next_state = ST_NORMALIZE;
      ST_NORMALIZE: next_state = ST_ROUND;
      ST_ROUND:     next_state = ST_DONE;
      default:      next_state = ST_IDLE;           // DONE and unused codes
    endcase
  end

  // Operands are captured on the same edge that accepts start
  assign unpack_en    = (state == ST_IDLE) && start;
  assign align_en     = (state == ST_ALIGN);
  assign compute_en   = (state == ST_COMPUTE);
  assign normalize_en = (state == ST_NORMALIZE);
  assign round_en     = (state == ST_ROUND);

  assign busy = (state != ST_IDLE) && (state != ST_DONE);
  assign done = (state == ST_DONE);

endmodule

// File: common/fp_add_pkg.sv
/*
 * Shared definitions for the single-precision FP adder: format constants,
 * rounding-mode codes, sequencer state codes and the float word views
 */
package fp_add_pkg;

  // ============================================================
  // IEEE 754 single-precision format
  // ============================================================
  localparam int EXP_WIDTH = 8;
  localparam int MAN_WIDTH = 23;
  localparam int FP_WIDTH  = 32;
  localparam int EXP_MAX   = 255;                    // Inf and NaN exponent

  // Hidden bit, fraction, then guard, round and sticky
  localparam int SIG_WIDTH = MAN_WIDTH + 4;

  localparam logic [FP_WIDTH-1:0] CANONICAL_NAN = 32'h7FC0_0000;

  // ============================================================
  // Rounding modes, unlisted codes behave as RTZ
  // ============================================================
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,                                   // Nearest, ties to even
    RM_RTZ = 3'd1,                                   // Toward zero
    RM_RDN = 3'd2,                                   // Toward minus infinity
    RM_RUP = 3'd3,                                   // Toward plus infinity
    RM_RMM = 3'd4                                    // Nearest, ties away
  } rm_t;

  // Stage sequencer states
  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_UNPACK    = 3'd1;
  localparam logic [2:0] ST_ALIGN     = 3'd2;
  localparam logic [2:0] ST_COMPUTE   = 3'd3;
  localparam logic [2:0] ST_NORMALIZE = 3'd4;
  localparam logic [2:0] ST_ROUND     = 3'd5;
  localparam logic [2:0] ST_DONE      = 3'd6;

  // ============================================================
  // One float word, seen as raw bits or as its fields
  // ============================================================
  typedef struct packed {
    logic                 sign;
    logic [EXP_WIDTH-1:0] exp;
    logic [MAN_WIDTH-1:0] frac;
  } fp_fields_t;

  typedef union packed {
    logic [FP_WIDTH-1:0] bits;
    fp_fields_t          fields;
  } fp_word_u;

endpackage
